//--- acq_pkg.sv
`default_nettype none

package acq_pkg;

////////////////////////////////////////////////////////////
// record field widths, fixed by the header layouts
////////////////////////////////////////////////////////////

localparam int WORD_W      = 128;  // one ddr3 fifo word
localparam int PAIR_W      = 26;   // two 12-bit samples plus two over-range bits
localparam int BURST_W     = 23;   // burst count and burst address
localparam int WAVE_W      = 12;   // waveform count and waveform number
localparam int GAP_W       = 22;   // idle cycles between waveforms
localparam int FILL_NUM_W  = 24;   // fill number
localparam int TAG_W       = 16;   // channel tag
localparam int FILL_TYPE_W = 2;    // fill type

typedef logic [WORD_W-1:0] acq_word_t;  // header, data or checksum word

////////////////////////////////////////////////////////////
// sequencer states and word opcodes
////////////////////////////////////////////////////////////

typedef enum logic [2:0] {
    st_idle     = 3'd0,  // waiting for fill_start
    st_fill_hdr = 3'd1,  // counter load, then fill header
    st_wave_hdr = 3'd2,  // one waveform header
    st_data     = 3'd3,  // data words on adc_valid
    st_gap      = 3'd4,  // idle between waveforms
    st_checksum = 3'd5   // closing word
} acq_state_e;

typedef enum logic [1:0] {
    sel_fill_hdr = 2'd0,
    sel_wave_hdr = 2'd1,
    sel_data     = 2'd2,
    sel_checksum = 2'd3
} word_sel_e;

endpackage

`default_nettype wire

//--- acq_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module acq_fsm (
    input  wire                clk,
    input  wire                rst_n,
    input  wire                fill_start,   // one-cycle pulse
    input  wire                adc_valid,    // sample pairs valid this cycle
    input  wire                words_last,   // last data word of this waveform
    input  wire                waves_last,   // last waveform of the fill
    input  wire                gap_done,     // gap over, or zero gap on load
    output logic               busy,
    output logic               fill_done,
    output logic               load_words,
    output logic               step_word,
    output logic               load_waves,
    output logic               step_wave,
    output logic               load_gap,
    output logic               word_strobe,  // emit one word this cycle
    output acq_pkg::word_sel_e word_sel      // which word
);

acq_pkg::acq_state_e state;      // current phase
acq_pkg::acq_state_e state_nxt;
logic                hdr_armed;  // second cycle of st_fill_hdr
logic                data_take;  // data word accepted
logic                wave_end;   // last data word of a waveform

////////////////////////////////////////////////////////////
// state register
////////////////////////////////////////////////////////////

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        state     <= acq_pkg::st_idle;
        hdr_armed <= 1'b0;
        fill_done <= 1'b0;
    end else begin
        state     <= state_nxt;
        hdr_armed <= (state == acq_pkg::st_fill_hdr) && !hdr_armed;  // load cycle first
        fill_done <= (state == acq_pkg::st_checksum);                // lines up with out_valid
    end
end

////////////////////////////////////////////////////////////
// next state
////////////////////////////////////////////////////////////

always_comb begin
    state_nxt = state;
    case (state)
        acq_pkg::st_idle: begin
            if (fill_start) begin
                state_nxt = acq_pkg::st_fill_hdr;
            end
        end
        acq_pkg::st_fill_hdr: begin
            if (hdr_armed) begin  // header goes out this cycle
                state_nxt = acq_pkg::st_wave_hdr;
            end
        end
        acq_pkg::st_wave_hdr: begin
            state_nxt = acq_pkg::st_data;
        end
        acq_pkg::st_data: begin
            if (wave_end) begin
                if (waves_last) begin
                    state_nxt = acq_pkg::st_checksum;
                end else if (gap_done) begin  // zero gap
                    state_nxt = acq_pkg::st_wave_hdr;
                end else begin
                    state_nxt = acq_pkg::st_gap;
                end
            end
        end
        acq_pkg::st_gap: begin
            if (gap_done) begin
                state_nxt = acq_pkg::st_wave_hdr;
            end
        end
        acq_pkg::st_checksum: begin
            state_nxt = acq_pkg::st_idle;
        end
        default: begin
            state_nxt = acq_pkg::st_idle;
        end
    endcase
end

////////////////////////////////////////////////////////////
// counter controls and word strobe
////////////////////////////////////////////////////////////

assign data_take = (state == acq_pkg::st_data) && adc_valid;  // adc_valid ignored elsewhere
assign wave_end  = data_take && words_last;

assign busy       = (state != acq_pkg::st_idle);
assign load_waves = (state == acq_pkg::st_fill_hdr) && !hdr_armed;
assign load_words = (state == acq_pkg::st_wave_hdr);  // reload per waveform
assign step_word  = data_take;
assign step_wave  = wave_end && !waves_last;          // next waveform number
assign load_gap   = wave_end && !waves_last;

assign word_strobe = ((state == acq_pkg::st_fill_hdr) && hdr_armed)
                   || (state == acq_pkg::st_wave_hdr)
                   || data_take
                   || (state == acq_pkg::st_checksum);

always_comb begin
    case (state)
        acq_pkg::st_fill_hdr: word_sel = acq_pkg::sel_fill_hdr;
        acq_pkg::st_wave_hdr: word_sel = acq_pkg::sel_wave_hdr;
        acq_pkg::st_checksum: word_sel = acq_pkg::sel_checksum;
        default:              word_sel = acq_pkg::sel_data;  // no strobe in idle or gap
    endcase
end

// no word may leave while idle or in a gap
a_no_strobe_idle_gap: assert property (
    @(posedge clk) disable iff (!rst_n)
    (state inside {acq_pkg::st_idle, acq_pkg::st_gap}) |-> !word_strobe
);

endmodule

`default_nettype wire

//--- acq_counter.sv
`timescale 1ns/10ps
`default_nettype none

module acq_counter (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire [acq_pkg::BURST_W-1:0]  num_fill_bursts,  // data words per waveform
    input  wire [acq_pkg::WAVE_W-1:0]   num_waveforms,
    input  wire [acq_pkg::GAP_W-1:0]    waveform_gap,
    input  wire                         load_words,
    input  wire                         step_word,
    input  wire                         load_waves,
    input  wire                         step_wave,
    input  wire                         load_gap,
    output logic                        words_last,
    output logic                        waves_last,
    output logic                        gap_done,
    output logic [acq_pkg::WAVE_W-1:0]  current_waveform_num
);

logic [acq_pkg::BURST_W-1:0] words_left;  // data words left in this waveform
logic [acq_pkg::WAVE_W-1:0]  waves_left;  // waveforms left in the fill
logic [acq_pkg::GAP_W-1:0]   gap_left;    // idle cycles left

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        words_left           <= '0;
        waves_left           <= '0;
        gap_left             <= '0;
        current_waveform_num <= '0;
    end else begin
        if (load_words) begin
            words_left <= num_fill_bursts;
        end else if (step_word) begin
            words_left <= words_left - 1'b1;
        end
        if (load_waves) begin
            waves_left           <= num_waveforms;
            current_waveform_num <= '0;  // numbering starts at 0
        end else if (step_wave) begin
            waves_left           <= waves_left - 1'b1;
            current_waveform_num <= current_waveform_num + 1'b1;
        end
        if (load_gap) begin
            gap_left <= waveform_gap;
        end else if (gap_left != '0) begin
            gap_left <= gap_left - 1'b1;  // free running down to zero
        end
    end
end

assign words_last = (words_left == acq_pkg::BURST_W'(1));
assign waves_last = (waves_left == acq_pkg::WAVE_W'(1));
// on load only a zero gap is done, later the last gap cycle ends it
assign gap_done   = load_gap ? (waveform_gap == '0) : (gap_left <= acq_pkg::GAP_W'(1));

a_step_word_nonzero: assert property (
    @(posedge clk) disable iff (!rst_n) step_word |-> (words_left != '0)
);
a_step_wave_nonzero: assert property (
    @(posedge clk) disable iff (!rst_n) step_wave |-> (waves_left != '0)
);

endmodule

`default_nettype wire

//--- acq_record_mux.sv
`timescale 1ns/10ps
`default_nettype none

module acq_record_mux (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire [acq_pkg::PAIR_W-1:0]      dat0,                  // oldest sample pair
    input  wire [acq_pkg::PAIR_W-1:0]      dat1,
    input  wire [acq_pkg::PAIR_W-1:0]      dat2,
    input  wire [acq_pkg::PAIR_W-1:0]      dat3,                  // newest sample pair
    input  wire [acq_pkg::FILL_TYPE_W-1:0] fill_type,
    input  wire [acq_pkg::FILL_NUM_W-1:0]  fill_num,
    input  wire [acq_pkg::BURST_W-1:0]     num_fill_bursts,
    input  wire [acq_pkg::BURST_W-1:0]     burst_start_adr,       // ddr3 burst address
    input  wire [acq_pkg::WAVE_W-1:0]      num_waveforms,
    input  wire [acq_pkg::WAVE_W-1:0]      current_waveform_num,
    input  wire [acq_pkg::GAP_W-1:0]       waveform_gap,
    input  wire [acq_pkg::TAG_W-1:0]       channel_tag,
    input  wire                            word_strobe,
    input  wire acq_pkg::word_sel_e        word_sel,
    output acq_pkg::acq_word_t             out_dat,
    output acq_pkg::word_sel_e             out_kind,
    output logic                           out_valid
);

localparam int SAMPLE_W  = 12;  // adc bits kept per sample
localparam int SLOT_W    = 16;  // sample slot in the output word
localparam int NUM_PAIRS = 4;
localparam int HI_LSB    = acq_pkg::PAIR_W - SAMPLE_W;  // upper sample starts at bit 14

acq_pkg::acq_word_t         fill_header;
acq_pkg::acq_word_t         wave_header;
acq_pkg::acq_word_t         data_word;
acq_pkg::acq_word_t         checksum;       // xor of every word so far
logic [acq_pkg::PAIR_W-1:0] pair [NUM_PAIRS];

////////////////////////////////////////////////////////////
// headers
////////////////////////////////////////////////////////////

// 2'b01 tag on top, sign-extended data only ever shows 00 or 11 there
assign fill_header = {
    2'b01,            // 127:126 header tag
    channel_tag,      // 125:110
    waveform_gap,     // 109:88
    num_waveforms,    // 87:76
    burst_start_adr,  // 75:53
    3'b000,           // 52:50 burst address is 8-word aligned
    num_fill_bursts,  // 49:27
    1'b0,             // 26 reserved
    fill_type,        // 25:24
    fill_num          // 23:0
};

assign wave_header = {
    2'b01,                 // 127:126 header tag
    12'b0,                 // 125:114 spare
    channel_tag,           // 113:98
    waveform_gap,          // 97:76
    current_waveform_num,  // 75:64
    num_waveforms,         // 63:52
    burst_start_adr,       // 51:29
    3'b000,                // 28:26
    num_fill_bursts,       // 25:3
    1'b0,                  // 2 reserved
    fill_type              // 1:0
};

////////////////////////////////////////////////////////////
// sample packing
////////////////////////////////////////////////////////////

assign pair[0] = dat0;
assign pair[1] = dat1;
assign pair[2] = dat2;
assign pair[3] = dat3;

// over-range bits 0 and 13 are dropped, each sample sign extended
always_comb begin
    data_word = '0;
    for (int p = 0; p < NUM_PAIRS; p++) begin
        data_word[2*p*SLOT_W +: SLOT_W] =
            {{(SLOT_W-SAMPLE_W){pair[p][SAMPLE_W]}}, pair[p][SAMPLE_W:1]};
        data_word[(2*p+1)*SLOT_W +: SLOT_W] =
            {{(SLOT_W-SAMPLE_W){pair[p][acq_pkg::PAIR_W-1]}}, pair[p][acq_pkg::PAIR_W-1:HI_LSB]};
    end
end

////////////////////////////////////////////////////////////
// output word and running checksum
////////////////////////////////////////////////////////////

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        out_valid <= 1'b0;
    end else begin
        out_valid <= word_strobe;  // one cycle behind the strobe
    end
end

always_ff @(posedge clk) begin
    if (word_strobe) begin
        out_kind <= word_sel;
        case (word_sel)
            acq_pkg::sel_fill_hdr: begin
                out_dat  <= fill_header;
                checksum <= fill_header;  // new fill restarts the sum
            end
            acq_pkg::sel_wave_hdr: begin
                out_dat  <= wave_header;
                checksum <= checksum ^ wave_header;
            end
            acq_pkg::sel_data: begin
                out_dat  <= data_word;
                checksum <= checksum ^ data_word;
            end
            default: begin
                out_dat <= checksum;  // closing word, sum held
            end
        endcase
    end
end

// the sequencer must hand over a defined opcode with every strobe
a_sel_known: assert property (
    @(posedge clk) disable iff (!rst_n) word_strobe |-> !$isunknown(word_sel)
);

endmodule

`default_nettype wire

//--- acq_writer.sv
`timescale 1ns/10ps
`default_nettype none

module acq_writer (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire                            fill_start,
    input  wire [acq_pkg::FILL_TYPE_W-1:0] fill_type,        // stable while busy
    input  wire [acq_pkg::FILL_NUM_W-1:0]  fill_num,
    input  wire [acq_pkg::BURST_W-1:0]     num_fill_bursts,
    input  wire [acq_pkg::BURST_W-1:0]     burst_start_adr,
    input  wire [acq_pkg::WAVE_W-1:0]      num_waveforms,
    input  wire [acq_pkg::GAP_W-1:0]       waveform_gap,
    input  wire [acq_pkg::TAG_W-1:0]       channel_tag,
    input  wire [acq_pkg::PAIR_W-1:0]      dat0,
    input  wire [acq_pkg::PAIR_W-1:0]      dat1,
    input  wire [acq_pkg::PAIR_W-1:0]      dat2,
    input  wire [acq_pkg::PAIR_W-1:0]      dat3,
    input  wire                            adc_valid,
    output acq_pkg::acq_word_t             out_dat,          // to the ddr3 write fifo
    output acq_pkg::word_sel_e             out_kind,
    output logic                           out_valid,
    output logic                           busy,
    output logic                           fill_done
);

logic                        load_words;  // sequencer to counter
logic                        step_word;
logic                        load_waves;
logic                        step_wave;
logic                        load_gap;
logic                        words_last;  // counter to sequencer
logic                        waves_last;
logic                        gap_done;
logic [acq_pkg::WAVE_W-1:0]  current_waveform_num;
logic                        word_strobe; // sequencer to mux
acq_pkg::word_sel_e          word_sel;

acq_fsm fsm_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .fill_start  (fill_start),
    .adc_valid   (adc_valid),
    .words_last  (words_last),
    .waves_last  (waves_last),
    .gap_done    (gap_done),
    .busy        (busy),
    .fill_done   (fill_done),
    .load_words  (load_words),
    .step_word   (step_word),
    .load_waves  (load_waves),
    .step_wave   (step_wave),
    .load_gap    (load_gap),
    .word_strobe (word_strobe),
    .word_sel    (word_sel)
);

acq_counter counter_i (
    .clk                  (clk),
    .rst_n                (rst_n),
    .num_fill_bursts      (num_fill_bursts),
    .num_waveforms        (num_waveforms),
    .waveform_gap         (waveform_gap),
    .load_words           (load_words),
    .step_word            (step_word),
    .load_waves           (load_waves),
    .step_wave            (step_wave),
    .load_gap             (load_gap),
    .words_last           (words_last),
    .waves_last           (waves_last),
    .gap_done             (gap_done),
    .current_waveform_num (current_waveform_num)
);

acq_record_mux mux_i (
    .clk                  (clk),
    .rst_n                (rst_n),
    .dat0                 (dat0),
    .dat1                 (dat1),
    .dat2                 (dat2),
    .dat3                 (dat3),
    .fill_type            (fill_type),
    .fill_num             (fill_num),
    .num_fill_bursts      (num_fill_bursts),
    .burst_start_adr      (burst_start_adr),
    .num_waveforms        (num_waveforms),
    .current_waveform_num (current_waveform_num),
    .waveform_gap         (waveform_gap),
    .channel_tag          (channel_tag),
    .word_strobe          (word_strobe),
    .word_sel             (word_sel),
    .out_dat              (out_dat),
    .out_kind             (out_kind),
    .out_valid            (out_valid)
);

endmodule

`default_nettype wire

//--- acq_tb_clk.sv
`timescale 1ns/10ps
`default_nettype none

module acq_tb_clk (
    output logic clk,
    output logic rst_n
);

initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;  // 100 ns period
end

initial begin
    rst_n = 1'b0;
    repeat (10) @(posedge clk);  // 10 cycles in reset
    @(negedge clk);
    rst_n = 1'b1;  // released away from the active edge
end

endmodule

`default_nettype wire

//--- acq_writer_tb.sv
`timescale 1ns/10ps
`default_nettype none

module acq_writer_tb;

localparam int WAIT_LIMIT = 200;  // cycles allowed per wait loop

logic                            clk;
logic                            rst_n;
logic                            fill_start;
logic [acq_pkg::FILL_TYPE_W-1:0] fill_type;
logic [acq_pkg::FILL_NUM_W-1:0]  fill_num;
logic [acq_pkg::BURST_W-1:0]     num_fill_bursts;
logic [acq_pkg::BURST_W-1:0]     burst_start_adr;
logic [acq_pkg::WAVE_W-1:0]      num_waveforms;
logic [acq_pkg::GAP_W-1:0]       waveform_gap;
logic [acq_pkg::TAG_W-1:0]       channel_tag;
logic [acq_pkg::PAIR_W-1:0]      dat0;
logic [acq_pkg::PAIR_W-1:0]      dat1;
logic [acq_pkg::PAIR_W-1:0]      dat2;
logic [acq_pkg::PAIR_W-1:0]      dat3;
logic                            adc_valid;
acq_pkg::acq_word_t              out_dat;
acq_pkg::word_sel_e              out_kind;
logic                            out_valid;
logic                            busy;
logic                            fill_done;

logic [31:0]                lfsr;           // galois state
acq_pkg::acq_word_t         exp_words [$];  // expected record, in order
acq_pkg::word_sel_e         exp_kinds [$];
logic [acq_pkg::PAIR_W-1:0] samples [$];    // four pairs per data word
string                      cur_test;
int                         err_count;
int                         tests_run;
int                         tests_failed;
bit                         timed_out;
int                         idle_run;       // cycles since the last word
acq_pkg::word_sel_e         last_kind;

acq_tb_clk clk_gen_i (
    .clk   (clk),
    .rst_n (rst_n)
);

acq_writer acq_writer_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .fill_start      (fill_start),
    .fill_type       (fill_type),
    .fill_num        (fill_num),
    .num_fill_bursts (num_fill_bursts),
    .burst_start_adr (burst_start_adr),
    .num_waveforms   (num_waveforms),
    .waveform_gap    (waveform_gap),
    .channel_tag     (channel_tag),
    .dat0            (dat0),
    .dat1            (dat1),
    .dat2            (dat2),
    .dat3            (dat3),
    .adc_valid       (adc_valid),
    .out_dat         (out_dat),
    .out_kind        (out_kind),
    .out_valid       (out_valid),
    .busy            (busy),
    .fill_done       (fill_done)
);

////////////////////////////////////////////////////////////
// random bits and expected record
////////////////////////////////////////////////////////////

function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
        val  = {val[30:0], lfsr[0]};  // bit shifted out
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return val;
endfunction

function automatic acq_pkg::acq_word_t fill_header_ref();
    acq_pkg::acq_word_t w;
    w = '0;
    w[127:126] = 2'b01;  // header tag
    w[125:110] = channel_tag;
    w[109:88]  = waveform_gap;
    w[87:76]   = num_waveforms;
    w[75:53]   = burst_start_adr;
    w[49:27]   = num_fill_bursts;
    w[25:24]   = fill_type;
    w[23:0]    = fill_num;
    return w;
endfunction

function automatic acq_pkg::acq_word_t wave_header_ref(input logic [acq_pkg::WAVE_W-1:0] wnum);
    acq_pkg::acq_word_t w;
    w = '0;  // spare and bit 2 stay zero
    w[127:126] = 2'b01;
    w[113:98]  = channel_tag;
    w[97:76]   = waveform_gap;
    w[75:64]   = wnum;
    w[63:52]   = num_waveforms;
    w[51:29]   = burst_start_adr;
    w[25:3]    = num_fill_bursts;
    w[1:0]     = fill_type;
    return w;
endfunction

function automatic logic [15:0] extend_sample(input logic signed [11:0] s);
    logic signed [15:0] e;
    e = s;  // signed widening
    return e;
endfunction

function automatic acq_pkg::acq_word_t data_ref(input int base);
    acq_pkg::acq_word_t         w;
    logic [acq_pkg::PAIR_W-1:0] p;
    w = '0;
    for (int k = 0; k < 4; k++) begin
        p = samples[base + k];
        w[32*k +: 16]      = extend_sample(p[12:1]);   // skip over-range bit 0
        w[32*k + 16 +: 16] = extend_sample(p[25:14]);  // skip over-range bit 13
    end
    return w;
endfunction

function automatic void build_expected(input int bursts, input int waves);
    acq_pkg::acq_word_t sum;
    acq_pkg::acq_word_t w;
    exp_words.delete();
    exp_kinds.delete();
    sum = fill_header_ref();
    exp_words.push_back(sum);
    exp_kinds.push_back(acq_pkg::sel_fill_hdr);
    for (int wv = 0; wv < waves; wv++) begin
        w   = wave_header_ref(acq_pkg::WAVE_W'(wv));
        sum = sum ^ w;
        exp_words.push_back(w);
        exp_kinds.push_back(acq_pkg::sel_wave_hdr);
        for (int b = 0; b < bursts; b++) begin
            w   = data_ref((wv * bursts + b) * 4);
            sum = sum ^ w;
            exp_words.push_back(w);
            exp_kinds.push_back(acq_pkg::sel_data);
        end
    end
    exp_words.push_back(sum);  // xor of everything before it
    exp_kinds.push_back(acq_pkg::sel_checksum);
endfunction

////////////////////////////////////////////////////////////
// compare tasks
////////////////////////////////////////////////////////////

task automatic check_word(input string what, input acq_pkg::acq_word_t exp,
                          input acq_pkg::acq_word_t act);
    if (act !== exp) begin
        $display("[ERROR] %s %s: expected %h actual %h", cur_test, what, exp, act);
        err_count++;
    end
endtask

task automatic check_kind(input string what, input acq_pkg::word_sel_e exp,
                          input acq_pkg::word_sel_e act);
    if (act !== exp) begin
        $display("[ERROR] %s %s: expected %s actual %s", cur_test, what, exp.name(), act.name());
        err_count++;
    end
endtask

task automatic check_flag(input string what, input logic exp, input logic act);
    if (act !== exp) begin
        $display("[ERROR] %s %s: expected %b actual %b", cur_test, what, exp, act);
        err_count++;
    end
endtask

task automatic check_count(input string what, input int exp, input int act);
    if (act != exp) begin
        $display("[ERROR] %s %s: expected %0d actual %0d", cur_test, what, exp, act);
        err_count++;
    end
endtask

task automatic report_timeout(input string what);
    acq_pkg::acq_state_e st;
    st = acq_writer_i.fsm_i.state;
    $display("timeout in %s while waiting for %s, sequencer in %s", cur_test, what, st.name());
    timed_out = 1'b1;
endtask

// outputs are registered, so the falling edge sees them settled
always @(negedge clk) begin : compare_words
    acq_pkg::acq_word_t exp_w;
    acq_pkg::word_sel_e exp_k;
    if (rst_n && out_valid) begin
        if (exp_words.size() == 0) begin
            $display("%s: word %h came out after the record was complete", cur_test, out_dat);
            err_count++;
        end else begin
            exp_w = exp_words.pop_front();
            exp_k = exp_kinds.pop_front();
            check_kind("word kind", exp_k, out_kind);
            check_word({exp_k.name(), " word"}, exp_w, out_dat);
            check_flag("fill_done with word", exp_k == acq_pkg::sel_checksum, fill_done);
            if (exp_k == acq_pkg::sel_checksum) begin
                check_flag("busy with checksum", 1'b0, busy);  // falls on the same edge
            end else begin
                check_flag("busy during fill", 1'b1, busy);  // more words still to come
            end
            if (exp_k == acq_pkg::sel_wave_hdr && last_kind == acq_pkg::sel_data) begin
                check_count("gap cycles", int'(waveform_gap), idle_run);
            end
        end
        last_kind = out_kind;
        idle_run  = 0;
    end else if (rst_n) begin
        idle_run++;
        check_flag("fill_done without word", 1'b0, fill_done);
    end
end

////////////////////////////////////////////////////////////
// stimulus
////////////////////////////////////////////////////////////

task automatic drive_quiet();
    fill_start = 1'b0;
    adc_valid  = 1'b0;
    dat0       = '0;
    dat1       = '0;
    dat2       = '0;
    dat3       = '0;
endtask

// outside st_data, none of this may reach the record
task automatic drive_junk(input bit mid_start);
    adc_valid  = 1'(rand_bits(1));
    dat0       = acq_pkg::PAIR_W'(rand_bits(acq_pkg::PAIR_W));
    dat1       = acq_pkg::PAIR_W'(rand_bits(acq_pkg::PAIR_W));
    dat2       = acq_pkg::PAIR_W'(rand_bits(acq_pkg::PAIR_W));
    dat3       = acq_pkg::PAIR_W'(rand_bits(acq_pkg::PAIR_W));
    fill_start = mid_start;  // must be ignored while busy
endtask

task automatic drive_pair(input int base);
    fill_start = 1'b0;
    adc_valid  = 1'b1;
    dat0       = samples[base];
    dat1       = samples[base + 1];
    dat2       = samples[base + 2];
    dat3       = samples[base + 3];
endtask

task automatic check_reset();
    int n;
    n = 0;
    while (rst_n !== 1'b1) begin
        @(negedge clk);
        n++;
        if (n > WAIT_LIMIT) begin
            report_timeout("reset release");
            return;
        end
    end
    repeat (8) begin  // nothing moves before fill_start
        check_flag("out_valid after reset", 1'b0, out_valid);
        check_flag("busy after reset", 1'b0, busy);
        check_flag("fill_done after reset", 1'b0, fill_done);
        @(negedge clk);
    end
endtask

task automatic wait_wave_header(input bit mid_start);
    int n;
    n = 0;
    while (!(out_valid && out_kind == acq_pkg::sel_wave_hdr)) begin
        drive_junk(mid_start);
        @(negedge clk);
        n++;
        if (n > WAIT_LIMIT) begin
            report_timeout("a waveform header");
            return;
        end
    end
endtask

task automatic run_fill(input int gap_force, input int waves_force, input bit mid_start);
    int bursts;
    int waves;
    int n;
    int pause;
    fill_type       = acq_pkg::FILL_TYPE_W'(rand_bits(acq_pkg::FILL_TYPE_W));
    fill_num        = acq_pkg::FILL_NUM_W'(rand_bits(acq_pkg::FILL_NUM_W));
    burst_start_adr = acq_pkg::BURST_W'(rand_bits(acq_pkg::BURST_W));
    channel_tag     = acq_pkg::TAG_W'(rand_bits(acq_pkg::TAG_W));
    bursts          = 1 + int'(rand_bits(2));
    waves           = (waves_force > 0) ? waves_force : 1 + int'(rand_bits(2)) % 3;
    num_fill_bursts = acq_pkg::BURST_W'(bursts);
    num_waveforms   = acq_pkg::WAVE_W'(waves);
    waveform_gap    = (gap_force >= 0) ? acq_pkg::GAP_W'(gap_force)
                                       : acq_pkg::GAP_W'(int'(rand_bits(3)) % 6);
    samples.delete();
    repeat (waves * bursts * 4) begin
        samples.push_back(acq_pkg::PAIR_W'(rand_bits(acq_pkg::PAIR_W)));
    end
    build_expected(bursts, waves);

    fill_start = 1'b1;
    n = 0;
    do begin
        @(negedge clk);
        n++;
        if (!out_valid) begin
            drive_junk(1'b0);  // also drops fill_start
        end
    end while (!out_valid && n < WAIT_LIMIT);
    if (!out_valid) begin
        report_timeout("the fill header");
        return;
    end
    check_count("fill header latency", 2, n - 1);

    for (int wv = 0; wv < waves; wv++) begin
        wait_wave_header(mid_start);
        if (timed_out) begin
            return;
        end
        for (int b = 0; b < bursts; b++) begin
            pause = int'(rand_bits(2)) % 3;  // adc_valid low for a while
            for (int i = 0; i < pause; i++) begin
                adc_valid = 1'b0;
                @(negedge clk);
            end
            drive_pair((wv * bursts + b) * 4);
            @(negedge clk);
        end
    end

    n = 0;
    while (!fill_done) begin
        drive_junk(mid_start);
        @(negedge clk);
        n++;
        if (n > WAIT_LIMIT) begin
            report_timeout("fill_done");
            return;
        end
    end
    drive_quiet();
    @(negedge clk);
    check_flag("busy after fill", 1'b0, busy);
    check_count("words still expected", 0, exp_words.size());
endtask

task automatic report_test(input int errs_before);
    tests_run++;
    if (err_count == errs_before && !timed_out) begin
        $display("test %s passed", cur_test);
    end else begin
        tests_failed++;
        $display("test %s failed with %0d errors", cur_test, err_count - errs_before);
    end
endtask

initial begin
    int errs_before;
    lfsr            = 32'h3e6a;
    err_count       = 0;
    tests_run       = 0;
    tests_failed    = 0;
    timed_out       = 1'b0;
    idle_run        = 0;
    last_kind       = acq_pkg::sel_checksum;
    fill_type       = '0;
    fill_num        = '0;
    num_fill_bursts = '0;
    burst_start_adr = '0;
    num_waveforms   = '0;
    waveform_gap    = '0;
    channel_tag     = '0;
    drive_quiet();

    for (int t = 0; t < 7 && !timed_out; t++) begin
        errs_before = err_count;
        case (t)
            0: begin
                cur_test = "reset_state";
                check_reset();
            end
            1: begin
                cur_test = "fill_random";
                run_fill(-1, 0, 1'b0);
            end
            2: begin
                cur_test = "fill_zero_gap";
                run_fill(0, 3, 1'b0);
            end
            3: begin
                cur_test = "fill_mid_start";
                run_fill(-1, 3, 1'b1);
            end
            default: begin
                cur_test = $sformatf("fill_random_%0d", t);
                run_fill(-1, 0, 1'b0);
            end
        endcase
        report_test(errs_before);
    end

    $display("tests %0d, failed %0d, errors %0d, timeouts %0d",
             tests_run, tests_failed, err_count, timed_out);
    if (err_count == 0 && !timed_out) begin
        $display("Finished with no errors");
    end else begin
        $display("Finished with errors");
    end
    $finish;
end

endmodule

`default_nettype wire

//--- acq_writer.f
acq_pkg.sv
acq_fsm.sv
acq_counter.sv
acq_record_mux.sv
acq_writer.sv
acq_tb_clk.sv
acq_writer_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the acq_writer testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -f acq_writer.f \
    --top-module acq_writer_tb -o acq_writer_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/acq_writer_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "simulation exited with an error, see sim.log"
    exit 1
fi

if grep -q "^Finished with no errors$" sim.log; then
    echo "PASS"
    exit 0
else
    echo "FAIL, see sim.log"
    exit 1
fi
